// ==== source/saturn_bus_pkg.sv ====
`default_nettype none

package saturn_bus_pkg;

    //////////////////////////////////////////////////
    // Bus command codes
    //////////////////////////////////////////////////

    // Codes 8 to 15 are legal on the bus and simply ignored.
    typedef enum logic [3:0] {
        PC_READ   = 4'd0,
        PC_WRITE  = 4'd1,
        DP_READ   = 4'd2,
        DP_WRITE  = 4'd3,
        LOAD_PC   = 4'd4,
        LOAD_DP   = 4'd5,
        CONFIGURE = 4'd6,
        RESET     = 4'd7
    } bus_cmd_t;

    //////////////////////////////////////////////////
    // Data and address types
    //////////////////////////////////////////////////

    localparam int PTR_WIDTH    = 20;       // Saturn address width.
    localparam int LOAD_NIBBLES = 5;        // Address nibbles per load.

    typedef logic [3:0]           nibble_t;
    typedef logic [PTR_WIDTH-1:0] bus_ptr_t;

    //////////////////////////////////////////////////
    // Stage to stage structs
    //////////////////////////////////////////////////

    // Decoder to pointer unit.
    typedef struct packed {
        logic       valid;                  // Data cycle on this edge.
        bus_cmd_t   cmd;                    // Command in force.
        logic [2:0] pos;                    // Address nibble position.
        nibble_t    data;                   // Nibble on the bus.
    } bus_op_t;

    // Pointer unit to nibble store.
    typedef struct packed {
        logic     rd;
        logic     wr;
        bus_ptr_t addr;
        nibble_t  wdata;
    } mem_access_t;

endpackage

`default_nettype wire

// ==== source/bus_cmd_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_cmd_decoder
    import saturn_bus_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    i_reset,
    input  wire logic    i_clk_en,
    input  wire logic    i_bus_clk_en,
    input  wire logic    i_bus_is_data,
    input  wire nibble_t i_bus_nibble_in,
    output bus_op_t      o_op
);

    //////////////////////////////////////////////////
    // Bus cycle qualification
    //////////////////////////////////////////////////

    logic     bus_cycle;
    logic     cmd_cycle;
    logic     data_cycle;
    bus_cmd_t nibble_cmd;

    assign bus_cycle  = i_clk_en & i_bus_clk_en;
    assign cmd_cycle  = bus_cycle & ~i_bus_is_data;
    assign data_cycle = bus_cycle & i_bus_is_data;
    assign nibble_cmd = bus_cmd_t'(i_bus_nibble_in);   // Any code is accepted.

    //////////////////////////////////////////////////
    // Last command and load position
    //////////////////////////////////////////////////

    bus_cmd_t   last_cmd;
    logic [2:0] pos;
    logic       in_load;
    logic       load_done;

    assign in_load   = (last_cmd == LOAD_PC) || (last_cmd == LOAD_DP);
    assign load_done = in_load && (pos == 3'(LOAD_NIBBLES - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            last_cmd <= PC_READ;
            pos      <= 3'd0;
        end else if (cmd_cycle) begin
            last_cmd <= nibble_cmd;
            // A new load starts with the least significant nibble.
            if ((nibble_cmd == LOAD_PC) || (nibble_cmd == LOAD_DP)) begin
                pos <= 3'd0;
            end
        end else if (data_cycle) begin
            if (in_load) begin
                pos <= pos + 3'd1;
            end
            // Fifth nibble in, fall into the matching read.
            if (load_done) begin
                if (last_cmd == LOAD_PC) begin
                    last_cmd <= PC_READ;
                end else begin
                    last_cmd <= DP_READ;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Operation to the pointer unit
    //////////////////////////////////////////////////

    always_comb begin
        o_op.valid = data_cycle;          // Command cycles stay in here.
        o_op.cmd   = last_cmd;
        o_op.pos   = pos;
        o_op.data  = i_bus_nibble_in;
    end

endmodule

`default_nettype wire

// ==== source/bus_pointer_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_pointer_unit
    import saturn_bus_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    i_reset,
    input  wire bus_op_t i_op,
    output mem_access_t  o_acc
);

    bus_ptr_t pc;
    bus_ptr_t dp;

    // Replace one address nibble of a pointer.
    function automatic bus_ptr_t load_nibble(
        input bus_ptr_t   ptr,
        input logic [2:0] pos,
        input nibble_t    data
    );
        bus_ptr_t result;
        result = ptr;
        for (int i = 0; i < LOAD_NIBBLES; i++) begin
            if (pos == 3'(i)) begin
                result[i*4 +: 4] = data;
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////
    // Memory access request
    //////////////////////////////////////////////////

    always_comb begin
        o_acc.rd    = 1'b0;
        o_acc.wr    = 1'b0;
        o_acc.addr  = pc;
        o_acc.wdata = i_op.data;
        case (i_op.cmd)
            PC_READ:  o_acc.rd = i_op.valid;
            PC_WRITE: o_acc.wr = i_op.valid;
            DP_READ: begin
                o_acc.rd   = i_op.valid;
                o_acc.addr = dp;
            end
            DP_WRITE: begin
                o_acc.wr   = i_op.valid;
                o_acc.addr = dp;
            end
            default: begin
                // Loads and ignored commands touch no memory.
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Pointer update
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc <= '0;
            dp <= '0;
        end else if (i_op.valid) begin
            case (i_op.cmd)
                PC_READ, PC_WRITE: pc <= pc + 20'd1;    // Wraps at 2^20.
                DP_READ, DP_WRITE: dp <= dp + 20'd1;
                LOAD_PC: pc <= load_nibble(pc, i_op.pos, i_op.data);
                LOAD_DP: dp <= load_nibble(dp, i_op.pos, i_op.data);
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/nibble_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module nibble_store
    import saturn_bus_pkg::*;
#(
    parameter int ADDR_BITS = 10
) (
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire mem_access_t i_acc,
    output nibble_t          o_bus_nibble_out
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    //////////////////////////////////////////////////
    // Storage array
    //////////////////////////////////////////////////

    nibble_t                mem [DEPTH];
    logic [ADDR_BITS-1:0]   index;

    // Upper pointer bits are dropped, so the array repeats across the space.
    assign index = i_acc.addr[ADDR_BITS-1:0];

    always_ff @(posedge i_clk) begin
        if (i_acc.wr) begin
            mem[index] <= i_acc.wdata;
        end
    end

    //////////////////////////////////////////////////
    // Registered read port
    //////////////////////////////////////////////////

    // Output holds until the next read cycle.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bus_nibble_out <= '0;
        end else if (i_acc.rd) begin
            o_bus_nibble_out <= mem[index];     // One clock latency.
        end
    end

endmodule

`default_nettype wire

// ==== source/saturn_bus_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module saturn_bus_ram
    import saturn_bus_pkg::*;
#(
    parameter int ADDR_BITS = 10                // Memory address bits, 1 to 20.
) (
    input  wire logic    i_clk,
    input  wire logic    i_reset,
    input  wire logic    i_clk_en,
    input  wire logic    i_bus_clk_en,
    input  wire logic    i_bus_is_data,
    input  wire nibble_t i_bus_nibble_in,
    output nibble_t      o_bus_nibble_out
);

    bus_op_t     op;                            // Decode to execute.
    mem_access_t acc;                           // Execute to memory.

    //////////////////////////////////////////////////
    // Command decoder
    //////////////////////////////////////////////////

    bus_cmd_decoder u_decoder (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_clk_en        (i_clk_en),
        .i_bus_clk_en    (i_bus_clk_en),
        .i_bus_is_data   (i_bus_is_data),
        .i_bus_nibble_in (i_bus_nibble_in),
        .o_op            (op)
    );

    //////////////////////////////////////////////////
    // PC and DP pointers
    //////////////////////////////////////////////////

    bus_pointer_unit u_pointers (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_op    (op),
        .o_acc   (acc)
    );

    //////////////////////////////////////////////////
    // Nibble memory
    //////////////////////////////////////////////////

    nibble_store #(
        .ADDR_BITS (ADDR_BITS)
    ) u_store (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_acc            (acc),
        .o_bus_nibble_out (o_bus_nibble_out)
    );

endmodule

`default_nettype wire

// ==== tb/bus_tasks.svh ====
`ifndef BUS_TASKS_SVH
`define BUS_TASKS_SVH

//////////////////////////////////////////////////
// Random numbers
//////////////////////////////////////////////////

logic [31:0] rand_state = 32'h60cf8c3e;

// One LCG step with the common 32-bit constants.
function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
endfunction

function automatic bus_ptr_t random_addr();
    logic [31:0] r;
    r = next_random();
    return r[31:12];                        // Upper bits are the better ones.
endfunction

function automatic nibble_t random_nibble();
    logic [31:0] r;
    r = next_random();
    return r[31:28];
endfunction

//////////////////////////////////////////////////
// Bus cycles
//////////////////////////////////////////////////

// Each task starts on a falling edge and returns on the next one.
task automatic send_cmd(input bus_cmd_t cmd);
    bus_is_data   = 1'b0;
    bus_nibble_in = nibble_t'(cmd);
    @(posedge clk);
    model_command(cmd);
    @(negedge clk);
    check_output();
endtask

task automatic data_cycle(input nibble_t data);
    bus_is_data   = 1'b1;
    bus_nibble_in = data;
    @(posedge clk);
    model_data(data);
    @(negedge clk);
    check_output();                         // Read value shows up here.
endtask

// Load command, then five address nibbles, low nibble first.
task automatic send_addr(input bus_cmd_t load_cmd, input bus_ptr_t addr);
    send_cmd(load_cmd);
    for (int i = 0; i < LOAD_NIBBLES; i++) begin
        data_cycle(addr[i*4 +: 4]);
    end
endtask

// A cycle with at least one enable low is not a bus cycle.
task automatic idle_cycle(
    input logic    clk_en_value,
    input logic    bus_clk_en_value,
    input logic    is_data,
    input nibble_t data
);
    clk_en        = clk_en_value;
    bus_clk_en    = bus_clk_en_value;
    bus_is_data   = is_data;
    bus_nibble_in = data;
    @(posedge clk);
    @(negedge clk);
    clk_en     = 1'b1;
    bus_clk_en = 1'b1;
    check_output();
endtask

`endif

// ==== tb/tb_saturn_bus_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_saturn_bus_ram
    import saturn_bus_pkg::*;
();

    localparam int ADDR_BITS     = 10;
    localparam int MODEL_DEPTH   = 2 ** ADDR_BITS;
    localparam int CLK_PERIOD    = 10;
    localparam int RESET_CYCLES  = 10;
    // Bus cycles of the five tests in order, after the first reset.
    localparam int TEST_CYCLES   = RESET_CYCLES + 25 + 45 + 68 + 21 + 70;
    localparam int MARGIN_CYCLES = 50;
    localparam int WATCHDOG_NS   = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

    logic    clk = 1'b0;
    logic    reset;
    logic    clk_en;
    logic    bus_clk_en;
    logic    bus_is_data;
    nibble_t bus_nibble_in;
    nibble_t bus_nibble_out;

    string   test_name;
    int      error_count = 0;

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    nibble_t  model_mem [MODEL_DEPTH];      // Unwritten entries stay unknown.
    bus_ptr_t model_pc;
    bus_ptr_t model_dp;
    bus_cmd_t model_cmd;
    int       model_pos;
    nibble_t  model_out;                    // Last value read.

    `include "bus_tasks.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    saturn_bus_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) dut (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_clk_en         (clk_en),
        .i_bus_clk_en     (bus_clk_en),
        .i_bus_is_data    (bus_is_data),
        .i_bus_nibble_in  (bus_nibble_in),
        .o_bus_nibble_out (bus_nibble_out)
    );

    function automatic int model_index(input bus_ptr_t addr);
        return int'(addr % MODEL_DEPTH);    // High bits alias.
    endfunction

    task automatic model_reset();
        model_cmd = PC_READ;
        model_pc  = '0;
        model_dp  = '0;
        model_pos = 0;
        model_out = '0;
    endtask

    task automatic model_command(input bus_cmd_t cmd);
        model_cmd = cmd;
        if ((cmd == LOAD_PC) || (cmd == LOAD_DP)) begin
            model_pos = 0;
        end
    endtask

    task automatic model_data(input nibble_t data);
        case (model_cmd)
            PC_READ: begin
                model_out = model_mem[model_index(model_pc)];
                model_pc  = model_pc + 1;
            end
            PC_WRITE: begin
                model_mem[model_index(model_pc)] = data;
                model_pc = model_pc + 1;
            end
            DP_READ: begin
                model_out = model_mem[model_index(model_dp)];
                model_dp  = model_dp + 1;
            end
            DP_WRITE: begin
                model_mem[model_index(model_dp)] = data;
                model_dp = model_dp + 1;
            end
            LOAD_PC: begin
                model_pc[model_pos*4 +: 4] = data;
                if (model_pos == LOAD_NIBBLES - 1) model_cmd = PC_READ;
                model_pos++;
            end
            LOAD_DP: begin
                model_dp[model_pos*4 +: 4] = data;
                if (model_pos == LOAD_NIBBLES - 1) model_cmd = DP_READ;
                model_pos++;
            end
            default: begin
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic stop_on_failure();
        error_count++;
        $display("FAIL: see errors above");
        $fatal(1, "Stopped at the first failure.");
    endtask

    task automatic check_output();
        assert (bus_nibble_out === model_out) else begin
            $display("Error: %s expected %h, actual %h", test_name, model_out,
                     bus_nibble_out);
            stop_on_failure();
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        model_reset();
        check_output();                     // Output must come out of reset as zero.
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        send_addr(LOAD_PC, 20'h00000);
        send_cmd(PC_WRITE);
        repeat (4) data_cycle(random_nibble());
        apply_reset();
        repeat (4) data_cycle(random_nibble()); // No command yet, so these read.
    endtask

    task automatic test_pc_write_read();
        bus_ptr_t addr;
        addr = random_addr();
        send_addr(LOAD_PC, addr);
        send_cmd(PC_WRITE);
        repeat (16) data_cycle(random_nibble());
        send_addr(LOAD_PC, addr);          // Falls into PC_READ.
        repeat (16) data_cycle(random_nibble());
    endtask

    task automatic test_dp_independent();
        bus_ptr_t pc_addr;
        bus_ptr_t dp_addr;
        pc_addr = random_addr();
        dp_addr = pc_addr ^ 20'h00200;      // Keeps the two areas apart.
        send_addr(LOAD_PC, pc_addr);
        send_addr(LOAD_DP, dp_addr);
        repeat (4) begin
            send_cmd(DP_WRITE);
            repeat (2) data_cycle(random_nibble());
            send_cmd(PC_WRITE);
            repeat (2) data_cycle(random_nibble());
        end
        send_addr(LOAD_PC, pc_addr);
        send_addr(LOAD_DP, dp_addr);
        repeat (2) begin
            send_cmd(PC_READ);
            repeat (4) data_cycle(random_nibble());
            send_cmd(DP_READ);
            repeat (4) data_cycle(random_nibble());
        end
    endtask

    task automatic test_aliasing();
        bus_ptr_t write_addr;
        bus_ptr_t read_addr;
        bus_ptr_t high;
        write_addr = random_addr() | 20'h00400;
        high       = random_addr();
        read_addr  = write_addr ^ {high[19:10] | 10'd1, 10'd0};
        send_addr(LOAD_PC, write_addr);
        send_cmd(PC_WRITE);
        repeat (4) data_cycle(random_nibble());
        send_addr(LOAD_DP, read_addr);
        repeat (4) data_cycle(random_nibble());
    endtask

    // Command that must leave memory, pointers and output alone.
    task automatic ignored_command(input bus_cmd_t cmd);
        send_cmd(cmd);
        repeat (3) data_cycle(random_nibble());
    endtask

    task automatic test_ignored_cycles();
        bus_ptr_t pc_addr;
        bus_ptr_t dp_addr;
        pc_addr = random_addr();
        dp_addr = pc_addr ^ 20'h00200;
        send_addr(LOAD_PC, pc_addr);
        send_cmd(PC_WRITE);
        repeat (8) data_cycle(random_nibble());
        send_addr(LOAD_DP, dp_addr);
        send_cmd(DP_WRITE);
        repeat (4) data_cycle(random_nibble());
        send_addr(LOAD_DP, dp_addr);
        data_cycle(random_nibble());
        send_addr(LOAD_PC, pc_addr);
        repeat (3) data_cycle(random_nibble());
        idle_cycle(1'b0, 1'b1, 1'b1, random_nibble());
        idle_cycle(1'b1, 1'b0, 1'b1, random_nibble());
        idle_cycle(1'b0, 1'b0, 1'b1, random_nibble());
        idle_cycle(1'b0, 1'b1, 1'b0, nibble_t'(LOAD_PC));
        idle_cycle(1'b1, 1'b0, 1'b0, nibble_t'(PC_WRITE));
        idle_cycle(1'b0, 1'b0, 1'b0, nibble_t'(LOAD_DP));
        data_cycle(random_nibble());        // Still PC_READ.
        ignored_command(CONFIGURE);
        ignored_command(RESET);
        ignored_command(bus_cmd_t'(4'hB));
        send_cmd(PC_READ);
        repeat (4) data_cycle(random_nibble());
        send_cmd(DP_READ);
        repeat (3) data_cycle(random_nibble());
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        reset         = 1'b1;
        clk_en        = 1'b1;
        bus_clk_en    = 1'b1;
        bus_is_data   = 1'b0;
        bus_nibble_in = '0;
        test_name     = "reset_state";
        apply_reset();
        test_reset_state();
        test_name = "pc_write_read";
        test_pc_write_read();
        test_name = "dp_independent";
        test_dp_independent();
        test_name = "aliasing";
        test_aliasing();
        test_name = "ignored_cycles";
        test_ignored_cycles();
        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns.", WATCHDOG_NS);
        stop_on_failure();
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+tb
source/saturn_bus_pkg.sv
source/bus_cmd_decoder.sv
source/bus_pointer_unit.sv
source/nibble_store.sv
source/saturn_bus_ram.sv
tb/tb_saturn_bus_ram.sv

// ==== Bender.yml ====
package:
  name: saturn_bus_ram

sources:
  # RTL in compile order.
  - files:
      - source/saturn_bus_pkg.sv
      - source/bus_cmd_decoder.sv
      - source/bus_pointer_unit.sv
      - source/nibble_store.sv
      - source/saturn_bus_ram.sv
  # Testbench.
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_saturn_bus_ram.sv
